/* hw/fft_pkg.sv */
package fft_pkg;

    localparam int fft_points = 16;
    localparam int fft_log2   = 4;
    localparam int num_stages = 2;
    localparam int din_width  = 16;
    localparam int dout_width = din_width + 2 * num_stages; // one bit per butterfly
    localparam int coef_width = 16;                         // Q1.14
    localparam int coef_frac  = 14;
    localparam int coef_one   = 1 << coef_frac;
    // total buffer fill of the chain (8+4+2+1), in samples
    localparam int pipe_delay = fft_points - 1;

    typedef enum logic [7:0] {
        ctrl    = 8'h00,
        status  = 8'h04,
        sample  = 8'h08,
        re_base = 8'h40,
        im_base = 8'h80
    } reg_addr_e;

    typedef enum logic [1:0] {
        bf_pass,
        bf_add,
        bf_add_j
    } bf_state_e;

    typedef enum logic {
        feed_collect,
        feed_flush
    } feed_state_e;

    function automatic logic [fft_log2-1:0] bit_reverse(input logic [fft_log2-1:0] idx);
        logic [fft_log2-1:0] r;
        for (int i = 0; i < fft_log2; i++)
            r[i] = idx[fft_log2-1-i];
        return r;
    endfunction

endpackage

/* hw/sdf_delay.sv */
`timescale 1ns/1ps

module sdf_delay #(
    parameter int depth = 4,
    parameter int width = 32
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             en,
    input  logic [width-1:0] din,
    output logic [width-1:0] dout
);
    logic [width-1:0] sr [0:depth-1];

    always_ff @(posedge clk) begin
        for (int i = 0; i < depth; i++) begin
            if (rst)
                sr[i] <= '0;
            else if (en)
                sr[i] <= (i == 0) ? din : sr[i-1];
        end
    end

    assign dout = sr[depth-1];
endmodule

/* hw/r22_bf1.sv */
`timescale 1ns/1ps

module r22_bf1 #(
    parameter int width       = 16,
    parameter int buffer_size = 8
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic signed [width-1:0] din_re,
    input  logic signed [width-1:0] din_im,
    input  logic                    din_valid,
    output logic signed [width:0]   dout_re,
    output logic signed [width:0]   dout_im,
    output logic                    dout_valid
);
    localparam int cbits = $clog2(buffer_size) + 1;

    logic [cbits-1:0]      cnt;
    fft_pkg::bf_state_e    state;
    logic signed [width:0] fb_in_re, fb_in_im, fb_re, fb_im;
    logic signed [width:0] out_re, out_im;

    always_ff @(posedge clk) begin
        if (rst)
            cnt <= '0;
        else if (din_valid)
            cnt <= cnt + 1'b1;
    end

    // second half of each 2*buffer_size window does the butterfly
    assign state = cnt[cbits-1] ? fft_pkg::bf_add : fft_pkg::bf_pass;

    always_comb begin
        if (state == fft_pkg::bf_add) begin
            fb_in_re = fb_re - din_re;
            fb_in_im = fb_im - din_im;
            out_re   = fb_re + din_re;
            out_im   = fb_im + din_im;
        end else begin
            fb_in_re = din_re; // store first half
            fb_in_im = din_im;
            out_re   = fb_re;  // drain previous differences
            out_im   = fb_im;
        end
    end

    sdf_delay #(.depth(buffer_size), .width(2 * width + 2)) u_fb (
        .clk  (clk),
        .rst  (rst),
        .en   (din_valid),
        .din  ({fb_in_re, fb_in_im}),
        .dout ({fb_re, fb_im})
    );

    always_ff @(posedge clk) begin
        if (rst)
            dout_valid <= 1'b0;
        else
            dout_valid <= din_valid;
        if (din_valid) begin
            dout_re <= out_re;
            dout_im <= out_im;
        end
    end

    // an unknown sample would poison the feedback delay for the rest of the frame
    a_din_known: assert property (@(posedge clk) disable iff (rst)
        din_valid |-> !$isunknown({din_re, din_im}));
endmodule

/* hw/r22_bf2.sv */
`timescale 1ns/1ps

module r22_bf2 #(
    parameter int width       = 17,
    parameter int buffer_size = 4
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic signed [width-1:0] din_re,
    input  logic signed [width-1:0] din_im,
    input  logic                    din_valid,
    output logic signed [width:0]   dout_re,
    output logic signed [width:0]   dout_im,
    output logic                    dout_valid
);
    localparam int cbits = $clog2(buffer_size) + 2;

    logic [cbits-1:0]      cnt;
    logic [1:0]            quarter;
    fft_pkg::bf_state_e    state;
    logic signed [width:0] x_re, x_im;
    logic signed [width:0] fb_in_re, fb_in_im, fb_re, fb_im;
    logic signed [width:0] out_re, out_im;

    always_ff @(posedge clk) begin
        if (rst)
            cnt <= '0;
        else if (din_valid)
            cnt <= cnt + 1'b1;
    end

    // input lags the window by the bf1 fill of 2*buffer_size, so the top bit flips
    assign quarter = {~cnt[cbits-1], cnt[cbits-2]};

    always_comb begin
        case (quarter)
            2'd1:    state = fft_pkg::bf_add;
            2'd3:    state = fft_pkg::bf_add_j;
            default: state = fft_pkg::bf_pass;
        endcase
    end

    always_comb begin
        x_re = din_re;
        x_im = din_im;
        if (state == fft_pkg::bf_add_j) begin
            x_re = din_im;  // times -j
            x_im = -din_re;
        end
        if (state == fft_pkg::bf_pass) begin
            fb_in_re = x_re;
            fb_in_im = x_im;
            out_re   = fb_re;
            out_im   = fb_im;
        end else begin
            fb_in_re = fb_re - x_re;
            fb_in_im = fb_im - x_im;
            out_re   = fb_re + x_re;
            out_im   = fb_im + x_im;
        end
    end

    sdf_delay #(.depth(buffer_size), .width(2 * width + 2)) u_fb (
        .clk  (clk),
        .rst  (rst),
        .en   (din_valid),
        .din  ({fb_in_re, fb_in_im}),
        .dout ({fb_re, fb_im})
    );

    always_ff @(posedge clk) begin
        if (rst)
            dout_valid <= 1'b0;
        else
            dout_valid <= din_valid;
        if (din_valid) begin
            dout_re <= out_re;
            dout_im <= out_im;
        end
    end

    a_dout_known: assert property (@(posedge clk) disable iff (rst)
        dout_valid |-> !$isunknown({dout_re, dout_im}));
endmodule

/* hw/twiddle_mult.sv */
`timescale 1ns/1ps

module twiddle_mult #(
    parameter int stage = 0,
    parameter int width = 18
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic signed [width-1:0] din_re,
    input  logic signed [width-1:0] din_im,
    input  logic                    din_valid,
    output logic signed [width-1:0] dout_re,
    output logic signed [width-1:0] dout_im,
    output logic                    dout_valid
);
    localparam int cw   = fft_pkg::coef_width;
    localparam int pw   = width + cw + 1;
    localparam int lat  = 3 * (fft_pkg::fft_points >> (2 * stage + 2)); // bf1+bf2 fill
    localparam bit last = (stage == fft_pkg::num_stages - 1);

    logic [fft_pkg::fft_log2-1:0] cnt, pos;
    logic [3:0]                   e;
    logic signed [cw-1:0]         c, s;
    logic signed [pw-1:0]         p_re, p_im;

    always_ff @(posedge clk) begin
        if (rst)
            cnt <= '0;
        else if (din_valid)
            cnt <= cnt + 1'b1;
    end

    assign pos = cnt - lat[fft_pkg::fft_log2-1:0];
    // group order 0,2,1,3 is the 2-bit reversal of the group index
    assign e   = last ? 4'd0 : pos[1:0] * {pos[2], pos[3]};

    always_comb begin
        case (e)
            4'd1:    begin c = 16'sd15137;  s = 16'sd6270;   end
            4'd2:    begin c = 16'sd11585;  s = 16'sd11585;  end
            4'd3:    begin c = 16'sd6270;   s = 16'sd15137;  end
            4'd4:    begin c = 16'sd0;      s = 16'sd16384;  end
            4'd6:    begin c = -16'sd11585; s = 16'sd11585;  end
            4'd9:    begin c = -16'sd15137; s = -16'sd6270;  end
            default: begin c = cw'(fft_pkg::coef_one); s = 16'sd0; end
        endcase
    end

    // (a + jb)(c - js)
    assign p_re = din_re * c + din_im * s + (pw'(1) <<< (fft_pkg::coef_frac - 1));
    assign p_im = din_im * c - din_re * s + (pw'(1) <<< (fft_pkg::coef_frac - 1));

    always_ff @(posedge clk) begin
        if (rst)
            dout_valid <= 1'b0;
        else
            dout_valid <= din_valid;
        if (din_valid) begin
            dout_re <= width'(p_re >>> fft_pkg::coef_frac);
            dout_im <= width'(p_im >>> fft_pkg::coef_frac);
        end
    end
endmodule

/* hw/r22_stage.sv */
`timescale 1ns/1ps

module r22_stage #(
    parameter int stage = 0
) (
    input  logic                                    clk,
    input  logic                                    rst,
    input  logic signed [fft_pkg::din_width+2*stage-1:0] din_re,
    input  logic signed [fft_pkg::din_width+2*stage-1:0] din_im,
    input  logic                                    din_valid,
    output logic signed [fft_pkg::din_width+2*stage+1:0] dout_re,
    output logic signed [fft_pkg::din_width+2*stage+1:0] dout_im,
    output logic                                    dout_valid
);
    localparam int w   = fft_pkg::din_width + 2 * stage;
    localparam int bf1 = fft_pkg::fft_points >> (2 * stage + 1);
    localparam int bf2 = fft_pkg::fft_points >> (2 * stage + 2);

    logic signed [w:0]   a_re, a_im;
    logic signed [w+1:0] b_re, b_im;
    logic                a_valid, b_valid;

    r22_bf1 #(.width(w), .buffer_size(bf1)) u_bf1 (
        .clk(clk), .rst(rst), .din_re(din_re), .din_im(din_im), .din_valid(din_valid),
        .dout_re(a_re), .dout_im(a_im), .dout_valid(a_valid)
    );

    r22_bf2 #(.width(w + 1), .buffer_size(bf2)) u_bf2 (
        .clk(clk), .rst(rst), .din_re(a_re), .din_im(a_im), .din_valid(a_valid),
        .dout_re(b_re), .dout_im(b_im), .dout_valid(b_valid)
    );

    twiddle_mult #(.stage(stage), .width(w + 2)) u_tw (
        .clk(clk), .rst(rst), .din_re(b_re), .din_im(b_im), .din_valid(b_valid),
        .dout_re(dout_re), .dout_im(dout_im), .dout_valid(dout_valid)
    );
endmodule

/* hw/fft_apb_regs.sv */
`timescale 1ns/1ps

module fft_apb_regs (
    input  logic                                    clk,
    input  logic                                    rst,
    input  logic                                    psel,
    input  logic                                    penable,
    input  logic                                    pwrite,
    input  logic [7:0]                              paddr,
    input  logic [31:0]                             pwdata,
    output logic [31:0]                             prdata,
    output logic                                    pready,
    output logic                                    pslverr,
    input  logic                                    done,
    output logic [3:0]                              rd_index,
    input  logic signed [fft_pkg::dout_width-1:0]   rd_re,
    input  logic signed [fft_pkg::dout_width-1:0]   rd_im,
    output logic signed [fft_pkg::din_width-1:0]    s0_re,
    output logic signed [fft_pkg::din_width-1:0]    s0_im,
    output logic                                    s0_valid,
    output logic                                    clear
);
    localparam int ew = 32 - fft_pkg::dout_width;

    fft_pkg::feed_state_e state;
    logic [4:0] samp_cnt;
    logic [3:0] flush_cnt;
    logic       access, is_ctrl, is_status, is_sample, is_re, is_im, mapped;
    logic       samp_ok, samp_wr;

    assign access    = psel & penable;
    assign is_ctrl   = (paddr == fft_pkg::ctrl);
    assign is_status = (paddr == fft_pkg::status);
    assign is_sample = (paddr == fft_pkg::sample);
    assign is_re     = (paddr[7:6] == fft_pkg::re_base[7:6]) && (paddr[1:0] == 2'b00);
    assign is_im     = (paddr[7:6] == fft_pkg::im_base[7:6]) && (paddr[1:0] == 2'b00);
    assign mapped    = is_ctrl | is_status | is_sample | is_re | is_im;

    assign samp_ok = !done && state == fft_pkg::feed_collect && samp_cnt < 5'd16;
    assign samp_wr = access & pwrite & is_sample & samp_ok;
    assign clear   = access & pwrite & is_ctrl & pwdata[0];

    assign pready  = 1'b1; // zero wait states
    assign pslverr = access & (~mapped | (pwrite & (is_status | is_re | is_im))
                               | (pwrite & is_sample & ~samp_ok));

    // flush pushes zeros so the frame drains out of the buffers
    assign s0_valid = samp_wr | (state == fft_pkg::feed_flush);
    assign s0_re    = (state == fft_pkg::feed_flush) ? '0 : pwdata[15:0];
    assign s0_im    = (state == fft_pkg::feed_flush) ? '0 : pwdata[31:16];
    assign rd_index = paddr[5:2];

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= fft_pkg::feed_collect;
            samp_cnt  <= '0;
            flush_cnt <= '0;
        end else begin
            if (clear)
                samp_cnt <= '0;
            else if (samp_wr)
                samp_cnt <= samp_cnt + 1'b1;
            case (state)
                fft_pkg::feed_collect: begin
                    flush_cnt <= '0;
                    if (samp_wr && samp_cnt == 5'd15)
                        state <= fft_pkg::feed_flush;
                end
                fft_pkg::feed_flush: begin
                    flush_cnt <= flush_cnt + 1'b1;
                    if (flush_cnt == 4'd15)
                        state <= fft_pkg::feed_collect;
                end
                default: state <= fft_pkg::feed_collect;
            endcase
        end
    end

    always_comb begin
        prdata = '0;
        if (access && !pwrite) begin
            if (is_status)
                prdata = {23'b0, samp_cnt, 3'b0, done};
            else if (is_re)
                prdata = {{ew{rd_re[fft_pkg::dout_width-1]}}, rd_re};
            else if (is_im)
                prdata = {{ew{rd_im[fft_pkg::dout_width-1]}}, rd_im};
        end
    end

    a_apb_enable: assert property (@(posedge clk) disable iff (rst) penable |-> psel);
endmodule

/* hw/fft_unscrambler.sv */
`timescale 1ns/1ps

module fft_unscrambler (
    input  logic                                  clk,
    input  logic                                  rst,
    input  logic signed [fft_pkg::dout_width-1:0] din_re,
    input  logic signed [fft_pkg::dout_width-1:0] din_im,
    input  logic                                  din_valid,
    input  logic                                  clear,
    input  logic [3:0]                            rd_index,
    output logic signed [fft_pkg::dout_width-1:0] rd_re,
    output logic signed [fft_pkg::dout_width-1:0] rd_im,
    output logic                                  done
);
    logic signed [fft_pkg::dout_width-1:0] mem_re [0:fft_pkg::fft_points-1];
    logic signed [fft_pkg::dout_width-1:0] mem_im [0:fft_pkg::fft_points-1];
    logic [4:0] cnt;
    logic [3:0] idx;
    logic       wr_en;

    // first outputs after clear are buffer leftovers of the previous flush
    assign idx   = 4'(cnt - 5'(fft_pkg::pipe_delay));
    assign wr_en = din_valid && cnt >= 5'(fft_pkg::pipe_delay)
                   && cnt < 5'(fft_pkg::pipe_delay + fft_pkg::fft_points);

    always_ff @(posedge clk) begin
        if (rst || clear) begin
            cnt  <= '0;
            done <= 1'b0;
        end else if (din_valid) begin
            cnt <= cnt + 1'b1;
            if (wr_en && idx == 4'd15)
                done <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem_re[fft_pkg::bit_reverse(idx)] <= din_re; // bins arrive bit-reversed
            mem_im[fft_pkg::bit_reverse(idx)] <= din_im;
        end
    end

    assign rd_re = mem_re[rd_index];
    assign rd_im = mem_im[rd_index];

    a_no_write_done: assert property (@(posedge clk) disable iff (rst) done |-> !wr_en);
endmodule

/* hw/fft16_top.sv */
`timescale 1ns/1ps

module fft16_top (
    input  logic        clk,
    input  logic        rst,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [7:0]  paddr,
    input  logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic        pready,
    output logic        pslverr
);
    localparam int dw = fft_pkg::dout_width;
    localparam int ns = fft_pkg::num_stages;

    logic signed [dw-1:0]                   st_re [0:ns];
    logic signed [dw-1:0]                   st_im [0:ns];
    logic [ns:0]                            st_valid;
    logic signed [fft_pkg::din_width-1:0]   s0_re, s0_im;
    logic signed [dw-1:0]                   rd_re, rd_im;
    logic [3:0]                             rd_index;
    logic                                   done, clear;

    fft_apb_regs u_regs (
        .clk(clk), .rst(rst), .psel(psel), .penable(penable), .pwrite(pwrite),
        .paddr(paddr), .pwdata(pwdata), .prdata(prdata), .pready(pready),
        .pslverr(pslverr), .done(done), .rd_index(rd_index), .rd_re(rd_re),
        .rd_im(rd_im), .s0_re(s0_re), .s0_im(s0_im), .s0_valid(st_valid[0]),
        .clear(clear)
    );

    assign st_re[0] = dw'(s0_re);
    assign st_im[0] = dw'(s0_im);

    for (genvar s = 0; s < ns; s++) begin : g_stage
        localparam int wi = fft_pkg::din_width + 2 * s;
        logic signed [wi+1:0] o_re, o_im;

        r22_stage #(.stage(s)) u_stage (
            .clk(clk), .rst(rst), .din_re(st_re[s][wi-1:0]), .din_im(st_im[s][wi-1:0]),
            .din_valid(st_valid[s]), .dout_re(o_re), .dout_im(o_im),
            .dout_valid(st_valid[s+1])
        );

        assign st_re[s+1] = dw'(o_re);
        assign st_im[s+1] = dw'(o_im);
    end

    fft_unscrambler u_drain (
        .clk(clk), .rst(rst), .din_re(st_re[ns]), .din_im(st_im[ns]),
        .din_valid(st_valid[ns]), .clear(clear), .rd_index(rd_index),
        .rd_re(rd_re), .rd_im(rd_im), .done(done)
    );
endmodule

/* verif/tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int period       = 40,
    parameter int reset_cycles = 16
) (
    output logic clk,
    output logic rst
);
    initial clk = 1'b0;
    always #(period / 2) clk = ~clk;

    initial begin
        rst = 1'b1;
        repeat (reset_cycles) @(posedge clk);
        rst <= 1'b0;
    end
endmodule

/* verif/fft16_tb.sv */
`timescale 1ns/1ps

module fft16_tb;
    localparam int  num_rows       = 10;
    localparam int  tol            = 4;    // twiddle rounding, in LSB
    localparam int  reset_cycles   = 16;
    localparam int  timeout_cycles = num_rows * 500 + reset_cycles;
    localparam real pi             = 3.14159265358979;

    typedef enum logic [2:0] {pat_impulse, pat_dc, pat_tone, pat_alt, pat_random} pat_e;

    logic        clk, rst;
    logic        psel, penable, pwrite;
    logic [7:0]  paddr;
    logic [31:0] pwdata, prdata;
    logic        pready, pslverr;

    pat_e row_kind [0:num_rows-1];
    int   row_amp  [0:num_rows-1];
    int   row_bin  [0:num_rows-1]; // tone bin, or sample index of the impulse
    int   x_re [0:15];
    int   x_im [0:15];
    real  ref_re [0:15];
    real  ref_im [0:15];
    int   cycles = 0;

    tb_clock_gen #(.period(40), .reset_cycles(reset_cycles)) u_clk (.clk(clk), .rst(rst));

    fft16_top u_fft16_top (
        .clk(clk), .rst(rst), .psel(psel), .penable(penable), .pwrite(pwrite),
        .paddr(paddr), .pwdata(pwdata), .prdata(prdata), .pready(pready), .pslverr(pslverr)
    );

    task automatic abort_run(string why);
        $display("%s", why);
        $display("Test failures found");
        $fatal(1);
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= timeout_cycles)
            abort_run($sformatf("timeout: run still busy after %0d cycles", cycles));
    end

    function automatic int round_int(real v);
        return (v >= 0.0) ? $rtoi(v + 0.5) : -$rtoi(0.5 - v);
    endfunction

    function automatic void set_row(int idx, pat_e kind, int amp, int bin);
        row_kind[idx] = kind;
        row_amp[idx]  = amp;
        row_bin[idx]  = bin;
    endfunction

    task automatic check_word(string name, logic [31:0] got, logic [31:0] exp);
        assert (got === exp)
            else abort_run($sformatf("MISMATCH %s got 0x%08h exp 0x%08h", name, got, exp));
    endtask

    task automatic check_bin(string name, int got, real exp);
        assert (got - exp <= tol && exp - got <= tol)
            else abort_run($sformatf("MISMATCH %s got 0x%08h exp 0x%08h", name, got,
                                     round_int(exp)));
    endtask

    // setup, access, then one idle cycle; sampled mid access phase
    task automatic apb_xfer(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
                            output logic [31:0] rdata, output logic err);
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= wr;
        paddr   <= addr;
        pwdata  <= wdata;
        @(posedge clk);
        penable <= 1'b1;
        @(negedge clk);
        rdata = prdata;
        err   = pslverr;
        check_word("pready", {31'b0, pready}, 32'h1);
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic write_reg(logic [7:0] addr, logic [31:0] data, logic exp_err);
        logic [31:0] rd;
        logic        err;
        apb_xfer(1'b1, addr, data, rd, err);
        check_word("pslverr", {31'b0, err}, {31'b0, exp_err});
    endtask

    task automatic read_reg(input logic [7:0] addr, output logic [31:0] data,
                            input logic exp_err);
        logic err;
        apb_xfer(1'b0, addr, 32'h0, data, err);
        check_word("pslverr", {31'b0, err}, {31'b0, exp_err});
    endtask

    function automatic void fill_frame(int r);
        real ang;
        for (int n = 0; n < 16; n++) begin
            ang = 2.0 * pi * row_bin[r] * n / 16.0;
            case (row_kind[r])
                pat_impulse: x_re[n] = (n == row_bin[r]) ? row_amp[r] : 0;
                pat_dc:      x_re[n] = row_amp[r];
                pat_tone:    x_re[n] = round_int(row_amp[r] * $cos(ang));
                pat_alt:     x_re[n] = (n % 2 == 0) ? row_amp[r] : -row_amp[r];
                default:     x_re[n] = int'($urandom_range(2 * row_amp[r], 0)) - row_amp[r];
            endcase
            case (row_kind[r])
                pat_tone:   x_im[n] = round_int(row_amp[r] * $sin(ang));
                pat_random: x_im[n] = int'($urandom_range(2 * row_amp[r], 0)) - row_amp[r];
                default:    x_im[n] = 0;
            endcase
        end
    endfunction

    // X[k] = sum x[n] (cos - j sin)(2 pi k n / 16)
    function automatic void compute_reference();
        real ang;
        for (int k = 0; k < 16; k++) begin
            ref_re[k] = 0.0;
            ref_im[k] = 0.0;
            for (int n = 0; n < 16; n++) begin
                ang = 2.0 * pi * k * n / 16.0;
                ref_re[k] += x_re[n] * $cos(ang) + x_im[n] * $sin(ang);
                ref_im[k] += x_im[n] * $cos(ang) - x_re[n] * $sin(ang);
            end
        end
    endfunction

    task automatic run_row(int r);
        logic [31:0] word;
        int          polls;
        write_reg(fft_pkg::ctrl, 32'h1, 1'b0);
        read_reg(fft_pkg::status, word, 1'b0);
        check_word("status", word, 32'h0);
        fill_frame(r);
        for (int n = 0; n < 16; n++)
            write_reg(fft_pkg::sample, {x_im[n][15:0], x_re[n][15:0]}, 1'b0);
        read_reg(fft_pkg::status, word, 1'b0);
        polls = 1;
        while (!word[0] && polls < 50) begin
            read_reg(fft_pkg::status, word, 1'b0);
            polls++;
        end
        assert (word[0])
            else abort_run($sformatf("done never rose for table row %0d", r));
        check_word("status", word, 32'h101); // 16 samples taken, done
        compute_reference();
        for (int k = 0; k < 16; k++) begin
            read_reg(8'(fft_pkg::re_base + 4 * k), word, 1'b0);
            check_bin($sformatf("re[%0d]", k), int'(word), ref_re[k]);
            read_reg(8'(fft_pkg::im_base + 4 * k), word, 1'b0);
            check_bin($sformatf("im[%0d]", k), int'(word), ref_im[k]);
        end
    endtask

    initial begin
        logic [31:0] word;
        string       order;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = 8'h0;
        pwdata  = 32'h0;
        void'($urandom(32'h284b_6f74));

        set_row(0, pat_impulse, 1000, 0);
        set_row(1, pat_impulse, -32768, 0);
        set_row(2, pat_impulse, 5000, 5);
        set_row(3, pat_dc, 32767, 0);   // bin 0 at full 20-bit scale
        set_row(4, pat_dc, -32768, 0);
        set_row(5, pat_tone, 2000, 3);
        set_row(6, pat_tone, 1800, 13);
        set_row(7, pat_alt, 16000, 0);
        set_row(8, pat_random, 2047, 0);
        set_row(9, pat_random, 1000, 0);

        order = "";
        for (int i = 0; i < 16; i++)
            order = {order, $sformatf(" %0d", fft_pkg::bit_reverse(4'(i)))};
        $display("bins leave the last stage in order:%s", order);

        wait (rst === 1'b0);
        read_reg(fft_pkg::status, word, 1'b0);
        check_word("status", word, 32'h0);
        read_reg(8'h0c, word, 1'b1);
        read_reg(8'hc0, word, 1'b1);
        check_word("prdata", word, 32'h0);
        write_reg(fft_pkg::status, 32'h1, 1'b1); // read-only offset

        for (int r = 0; r < num_rows; r++)
            run_row(r);

        // done still high from the last frame
        write_reg(fft_pkg::sample, 32'h1234_5678, 1'b1);
        read_reg(fft_pkg::status, word, 1'b0);
        check_word("status", word, 32'h101);

        $display("All tests passed!");
        $finish;
    end
endmodule

/* vlog.f */
hw/fft_pkg.sv
hw/sdf_delay.sv
hw/r22_bf1.sv
hw/r22_bf2.sv
hw/twiddle_mult.sv
hw/r22_stage.sv
hw/fft_apb_regs.sv
hw/fft_unscrambler.sv
hw/fft16_top.sv
verif/tb_clock_gen.sv
verif/fft16_tb.sv
